// ==== source/execPkg.sv ====
// Shared definitions for the integer execute pipeline
// Opcode bytes, internal ALU operations, flag classes and RFLAGS positions
`default_nettype none

package execPkg;

	parameter int DefaultDataWidth = 64;

	typedef logic [63:0] flagsT;

	// RFLAGS bit positions
	parameter int FlagCf = 0;
	parameter int FlagZf = 6;
	parameter int FlagSf = 7;
	parameter int FlagOf = 11;

	// One-byte opcodes handled by the execute stage
	typedef enum logic [7:0] {
		OpAddRm = 8'h01, OpAddR = 8'h03, OpAddAcc = 8'h05,
		OpOrRm = 8'h09, OpOrR = 8'h0B, OpOrAcc = 8'h0D,
		OpAdcRm = 8'h11, OpAdcR = 8'h13, OpAdcAcc = 8'h15,
		OpSbbRm = 8'h19, OpSbbR = 8'h1B, OpSbbAcc = 8'h1D,
		OpAndRm = 8'h21, OpAndR = 8'h23, OpAndAcc = 8'h25,
		OpSubRm = 8'h29, OpSubR = 8'h2B, OpSubAcc = 8'h2D,
		OpXorRm = 8'h31, OpXorR = 8'h33, OpXorAcc = 8'h35,
		OpCmpRm = 8'h39, OpCmpR = 8'h3B, OpCmpAcc = 8'h3D,
		OpGrp1Iv = 8'h81, OpGrp1Ib = 8'h83,
		OpMovStore = 8'h89, OpMovLoad = 8'h8B,
		OpNop = 8'h90,
		OpMovRax = 8'hB8, OpMovRcx = 8'hB9, OpMovRdx = 8'hBA, OpMovRbx = 8'hBB,
		OpMovRsp = 8'hBC, OpMovRbp = 8'hBD, OpMovRsi = 8'hBE, OpMovRdi = 8'hBF,
		OpRet = 8'hC3, OpMovImm = 8'hC7, OpRetFar = 8'hCB, OpIret = 8'hCF,
		OpGrp3 = 8'hF7, OpGrp5 = 8'hFF
	} opcodeE;

	typedef enum logic [4:0] {
		AluNop, AluMov, AluAdd, AluAdc, AluSub, AluSbb, AluCmp,
		AluAnd, AluOr, AluXor, AluNot, AluNeg, AluInc, AluDec,
		AluMul, AluKill, AluInvalid
	} aluOpE;

	// Which arithmetic flags the flag stage rewrites
	typedef enum logic [2:0] {
		ClassArith,
		ClassLogic,
		ClassIncDec,
		ClassMul,
		ClassNone
	} flagClassE;

endpackage

`default_nettype wire

// ==== source/execStageIf.sv ====
// Inter-stage buses of the execute pipeline
// decodeBusIf feeds the ALU stage, aluBusIf feeds the flag stage
`default_nettype none

interface decodeBusIf #(
	parameter int DataWidth = execPkg::DefaultDataWidth
);
	logic valid;
	execPkg::aluOpE aluOp;
	logic [DataWidth-1:0] operandA;
	logic [DataWidth-1:0] operandB;
	execPkg::flagsT flagsIn;
	logic ok;

	modport src (output valid, aluOp, operandA, operandB, flagsIn, ok);
	modport dst (input valid, aluOp, operandA, operandB, flagsIn, ok);
endinterface

interface aluBusIf #(
	parameter int DataWidth = execPkg::DefaultDataWidth
);
	logic valid;
	execPkg::flagClassE flagClass;
	logic [DataWidth-1:0] result;
	// Upper half of the MUL product, zero otherwise
	logic [DataWidth-1:0] resultHigh;
	logic carry;
	logic overflow;
	execPkg::flagsT flagsIn;
	logic kill;
	logic ok;

	modport src (
		output valid, flagClass, result, resultHigh, carry, overflow,
		output flagsIn, kill, ok
	);
	modport dst (
		input valid, flagClass, result, resultHigh, carry, overflow,
		input flagsIn, kill, ok
	);
endinterface

`default_nettype wire

// ==== source/decodeStage.sv ====
// Decode stage of the execute pipeline
// Maps opcode and ModRM extension to an ALU operation and picks the operands
`default_nettype none

module decodeStage #(
	parameter int DataWidth = execPkg::DefaultDataWidth
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbStall,
	input wire logic opValid,
	input wire logic canExecute,
	input wire execPkg::opcodeE opcode,
	input wire logic hasExtOpcode,
	input wire logic [2:0] extOpcode,
	input wire logic [DataWidth-1:0] operand1,
	input wire logic [DataWidth-1:0] operand2,
	input wire logic memSrc1,
	input wire logic memSrc2,
	input wire logic [DataWidth-1:0] memData,
	input wire logic [DataWidth-1:0] imm,
	input wire execPkg::flagsT flagsIn,
	decodeBusIf.src bus
);

	typedef enum logic [1:0] {SelSrc2, SelImm, SelOne} bSelE;

	logic accept;
	execPkg::aluOpE decOp;
	bSelE bSel;
	logic [DataWidth-1:0] srcA;
	logic [DataWidth-1:0] src2;
	logic [DataWidth-1:0] srcB;

	// Group 1 (81/83) extension field
	function automatic execPkg::aluOpE grp1Op(input logic [2:0] ext);
		case (ext)
			3'b000: return execPkg::AluAdd;
			3'b001: return execPkg::AluOr;
			3'b010: return execPkg::AluAdc;
			3'b011: return execPkg::AluSbb;
			3'b100: return execPkg::AluAnd;
			3'b101: return execPkg::AluSub;
			3'b110: return execPkg::AluXor;
			default: return execPkg::AluCmp;
		endcase
	endfunction

	assign accept = opValid && canExecute && !wbStall;

	always_comb begin
		decOp = execPkg::AluInvalid;
		bSel = SelSrc2;
		case (opcode)
			execPkg::OpNop: decOp = execPkg::AluNop;
			execPkg::OpMovImm: begin
				if (hasExtOpcode && extOpcode == 3'b000) begin
					decOp = execPkg::AluMov;
					bSel = SelImm;
				end
			end
			execPkg::OpMovStore, execPkg::OpMovLoad: decOp = execPkg::AluMov;
			execPkg::OpMovRax, execPkg::OpMovRcx, execPkg::OpMovRdx, execPkg::OpMovRbx,
			execPkg::OpMovRsp, execPkg::OpMovRbp, execPkg::OpMovRsi, execPkg::OpMovRdi: begin
				decOp = execPkg::AluMov;
				bSel = SelImm;
			end
			execPkg::OpGrp1Iv, execPkg::OpGrp1Ib: begin
				if (hasExtOpcode) begin
					decOp = grp1Op(extOpcode);
					bSel = SelImm;
				end
			end
			execPkg::OpGrp3: begin
				if (hasExtOpcode) begin
					case (extOpcode)
						3'b010: decOp = execPkg::AluNot;
						3'b011: decOp = execPkg::AluNeg;
						3'b100: decOp = execPkg::AluMul;
						default: decOp = execPkg::AluInvalid;
					endcase
				end
			end
			execPkg::OpGrp5: begin
				// INC and DEC reuse the adder with a constant one
				bSel = SelOne;
				if (hasExtOpcode && extOpcode == 3'b000) begin
					decOp = execPkg::AluInc;
				end else if (hasExtOpcode && extOpcode == 3'b001) begin
					decOp = execPkg::AluDec;
				end
			end
			execPkg::OpAddRm, execPkg::OpAddR: decOp = execPkg::AluAdd;
			execPkg::OpAdcRm, execPkg::OpAdcR: decOp = execPkg::AluAdc;
			execPkg::OpSbbRm, execPkg::OpSbbR: decOp = execPkg::AluSbb;
			execPkg::OpSubRm, execPkg::OpSubR: decOp = execPkg::AluSub;
			execPkg::OpCmpRm, execPkg::OpCmpR: decOp = execPkg::AluCmp;
			execPkg::OpOrRm, execPkg::OpOrR: decOp = execPkg::AluOr;
			execPkg::OpAndRm, execPkg::OpAndR: decOp = execPkg::AluAnd;
			execPkg::OpXorRm, execPkg::OpXorR: decOp = execPkg::AluXor;
			execPkg::OpAddAcc, execPkg::OpAdcAcc, execPkg::OpSbbAcc, execPkg::OpSubAcc,
			execPkg::OpCmpAcc, execPkg::OpOrAcc, execPkg::OpAndAcc, execPkg::OpXorAcc: begin
				// Accumulator forms share the group 1 ordering in opcode bits 5:3
				decOp = grp1Op(opcode[5:3]);
				bSel = SelImm;
			end
			execPkg::OpRet, execPkg::OpRetFar, execPkg::OpIret: decOp = execPkg::AluKill;
			default: decOp = execPkg::AluInvalid;
		endcase
	end

	// Memory data replaces whichever source is a memory operand
	assign srcA = memSrc1 ? memData : operand1;
	assign src2 = memSrc2 ? memData : operand2;

	always_comb begin
		case (bSel)
			SelImm: srcB = imm;
			SelOne: srcB = {{(DataWidth-1){1'b0}}, 1'b1};
			default: srcB = src2;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bus.valid <= 1'b0;
		end else if (!wbStall) begin
			bus.valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (!wbStall) begin
			bus.aluOp <= decOp;
			bus.operandA <= srcA;
			bus.operandB <= srcB;
			bus.flagsIn <= flagsIn;
			bus.ok <= (decOp != execPkg::AluInvalid);
		end
	end

	// Only one memory read port feeds the sources
	memSrcExclusive: assert property (@(posedge clk) disable iff (!rstN)
		accept |-> !(memSrc1 && memSrc2));

endmodule

`default_nettype wire

// ==== source/aluStage.sv ====
// ALU stage of the execute pipeline
// Adder/subtractor, logic ops and unsigned multiply with raw carry and overflow
`default_nettype none

module aluStage #(
	parameter int DataWidth = execPkg::DefaultDataWidth
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbStall,
	decodeBusIf.dst dec,
	aluBusIf.src alu
);

	logic [DataWidth-1:0] x;
	logic [DataWidth-1:0] y;
	logic carryIn;
	logic isSub;
	logic [DataWidth:0] sumExt;
	logic [2*DataWidth-1:0] product;
	logic [DataWidth-1:0] resultNext;
	logic [DataWidth-1:0] highNext;
	logic carryNext;
	logic overflowNext;
	logic killNext;
	execPkg::flagClassE classNext;

	assign product = {{DataWidth{1'b0}}, dec.operandA} * {{DataWidth{1'b0}}, dec.operandB};

	always_comb begin
		x = dec.operandA;
		y = dec.operandB;
		carryIn = 1'b0;
		isSub = 1'b0;
		case (dec.aluOp)
			execPkg::AluAdc: carryIn = dec.flagsIn[execPkg::FlagCf];
			execPkg::AluSub, execPkg::AluCmp, execPkg::AluDec: isSub = 1'b1;
			execPkg::AluSbb: begin
				isSub = 1'b1;
				carryIn = dec.flagsIn[execPkg::FlagCf];
			end
			execPkg::AluNeg: begin
				// NEG is 0 - A, so borrow and overflow fall out of the subtractor
				isSub = 1'b1;
				x = '0;
				y = dec.operandA;
			end
			default: isSub = 1'b0;
		endcase

		// Top bit is carry out for add, borrow for subtract
		if (isSub) begin
			sumExt = {1'b0, x} - {1'b0, y} - {{DataWidth{1'b0}}, carryIn};
			overflowNext = (x[DataWidth-1] != y[DataWidth-1]) &&
				(sumExt[DataWidth-1] != x[DataWidth-1]);
		end else begin
			sumExt = {1'b0, x} + {1'b0, y} + {{DataWidth{1'b0}}, carryIn};
			overflowNext = (x[DataWidth-1] == y[DataWidth-1]) &&
				(sumExt[DataWidth-1] != x[DataWidth-1]);
		end
		carryNext = sumExt[DataWidth];

		resultNext = '0;
		highNext = '0;
		killNext = 1'b0;
		classNext = execPkg::ClassNone;
		case (dec.aluOp)
			execPkg::AluAdd, execPkg::AluAdc, execPkg::AluSub, execPkg::AluSbb,
			execPkg::AluCmp, execPkg::AluNeg: begin
				resultNext = sumExt[DataWidth-1:0];
				classNext = execPkg::ClassArith;
			end
			execPkg::AluInc, execPkg::AluDec: begin
				resultNext = sumExt[DataWidth-1:0];
				classNext = execPkg::ClassIncDec;
			end
			execPkg::AluAnd: begin
				resultNext = dec.operandA & dec.operandB;
				classNext = execPkg::ClassLogic;
			end
			execPkg::AluOr: begin
				resultNext = dec.operandA | dec.operandB;
				classNext = execPkg::ClassLogic;
			end
			execPkg::AluXor: begin
				resultNext = dec.operandA ^ dec.operandB;
				classNext = execPkg::ClassLogic;
			end
			execPkg::AluNot: resultNext = ~dec.operandA;
			execPkg::AluMov: resultNext = dec.operandB;
			execPkg::AluMul: begin
				resultNext = product[DataWidth-1:0];
				highNext = product[2*DataWidth-1:DataWidth];
				// CF and OF both report a nonzero high half
				carryNext = |highNext;
				overflowNext = |highNext;
				classNext = execPkg::ClassMul;
			end
			execPkg::AluKill: killNext = 1'b1;
			default: resultNext = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			alu.valid <= 1'b0;
		end else if (!wbStall) begin
			alu.valid <= dec.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!wbStall) begin
			alu.flagClass <= classNext;
			alu.result <= resultNext;
			alu.resultHigh <= highNext;
			alu.carry <= carryNext;
			alu.overflow <= overflowNext;
			alu.flagsIn <= dec.flagsIn;
			alu.kill <= killNext;
			alu.ok <= dec.ok;
		end
	end

	invalidNeverOk: assert property (@(posedge clk) disable iff (!rstN)
		dec.valid |-> !(dec.aluOp == execPkg::AluInvalid && dec.ok));

endmodule

`default_nettype wire

// ==== source/flagStage.sv ====
// Flag stage of the execute pipeline
// Merges ZF, SF, CF and OF into RFLAGS and registers the unit outputs
`default_nettype none

module flagStage #(
	parameter int DataWidth = execPkg::DefaultDataWidth
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbStall,
	aluBusIf.dst alu,
	output logic [DataWidth-1:0] result,
	output logic [DataWidth-1:0] resultHigh,
	output execPkg::flagsT flagsOut,
	output logic done,
	output logic executeOk,
	output logic kill
);

	execPkg::flagsT flagsNext;
	logic zero;
	logic sign;

	assign zero = (alu.result == '0);
	assign sign = alu.result[DataWidth-1];

	always_comb begin
		flagsNext = alu.flagsIn;
		case (alu.flagClass)
			execPkg::ClassArith: begin
				flagsNext[execPkg::FlagZf] = zero;
				flagsNext[execPkg::FlagSf] = sign;
				flagsNext[execPkg::FlagCf] = alu.carry;
				flagsNext[execPkg::FlagOf] = alu.overflow;
			end
			execPkg::ClassLogic: begin
				flagsNext[execPkg::FlagZf] = zero;
				flagsNext[execPkg::FlagSf] = sign;
				flagsNext[execPkg::FlagCf] = 1'b0;
				flagsNext[execPkg::FlagOf] = 1'b0;
			end
			execPkg::ClassIncDec: begin
				// CF survives INC and DEC
				flagsNext[execPkg::FlagZf] = zero;
				flagsNext[execPkg::FlagSf] = sign;
				flagsNext[execPkg::FlagOf] = alu.overflow;
			end
			execPkg::ClassMul: begin
				flagsNext[execPkg::FlagCf] = alu.carry;
				flagsNext[execPkg::FlagOf] = alu.overflow;
			end
			default: flagsNext = alu.flagsIn;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			done <= 1'b0;
			executeOk <= 1'b0;
			kill <= 1'b0;
		end else if (!wbStall) begin
			done <= alu.valid;
			executeOk <= alu.valid && alu.ok;
			kill <= alu.valid && alu.kill;
		end
	end

	// Payload held with done while writeback stalls
	always_ff @(posedge clk) begin
		if (!wbStall) begin
			result <= alu.result;
			resultHigh <= alu.resultHigh;
			flagsOut <= flagsNext;
		end
	end

	killIsOk: assert property (@(posedge clk) disable iff (!rstN) kill |-> executeOk);

endmodule

`default_nettype wire

// ==== source/executeUnit.sv ====
// Integer execute unit, three-stage pipeline of decode, ALU and flag merge
// Accepted at edge N, done is registered at edge N+2 and seen at edge N+3
`default_nettype none

module executeUnit #(
	parameter int DataWidth = execPkg::DefaultDataWidth
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic opValid,
	input wire logic canExecute,
	input wire logic wbStall,
	input wire execPkg::opcodeE opcode,
	input wire logic hasExtOpcode,
	input wire logic [2:0] extOpcode,
	input wire logic [DataWidth-1:0] operand1,
	input wire logic [DataWidth-1:0] operand2,
	input wire logic memSrc1,
	input wire logic memSrc2,
	input wire logic [DataWidth-1:0] memData,
	input wire logic [DataWidth-1:0] imm,
	input wire execPkg::flagsT flagsIn,
	output logic [DataWidth-1:0] result,
	output logic [DataWidth-1:0] resultHigh,
	output execPkg::flagsT flagsOut,
	output logic done,
	output logic executeOk,
	output logic kill
);

	decodeBusIf #(.DataWidth(DataWidth)) decBus ();
	aluBusIf #(.DataWidth(DataWidth)) aluBus ();

	decodeStage #(.DataWidth(DataWidth)) decode_i (
		.clk(clk),
		.rstN(rstN),
		.wbStall(wbStall),
		.opValid(opValid),
		.canExecute(canExecute),
		.opcode(opcode),
		.hasExtOpcode(hasExtOpcode),
		.extOpcode(extOpcode),
		.operand1(operand1),
		.operand2(operand2),
		.memSrc1(memSrc1),
		.memSrc2(memSrc2),
		.memData(memData),
		.imm(imm),
		.flagsIn(flagsIn),
		.bus(decBus.src)
	);

	aluStage #(.DataWidth(DataWidth)) alu_i (
		.clk(clk),
		.rstN(rstN),
		.wbStall(wbStall),
		.dec(decBus.dst),
		.alu(aluBus.src)
	);

	flagStage #(.DataWidth(DataWidth)) flag_i (
		.clk(clk),
		.rstN(rstN),
		.wbStall(wbStall),
		.alu(aluBus.dst),
		.result(result),
		.resultHigh(resultHigh),
		.flagsOut(flagsOut),
		.done(done),
		.executeOk(executeOk),
		.kill(kill)
	);

endmodule

`default_nettype wire

// ==== dv/execVectors.svh ====
// Stimulus and expected values for the execute unit testbench
// Columns: opcode, hasExt, ext, operand1, operand2, memSel {src2,src1}, memData, imm, flagsIn
// then expected result, resultHigh, flags, ok, kill

task automatic loadVectors();
	// Add family with carry out, zero and signed overflow
	addVec(execPkg::OpAddRm, 1'b0, 3'd0, 64'd5, 64'd7, 2'b00, 64'd0, 64'd0, 64'h2,
		64'hC, 64'd0, 64'h2, 1'b1, 1'b0);
	addVec(execPkg::OpAddAcc, 1'b0, 3'd0, AllOnes, 64'd0, 2'b00, 64'd0, 64'd1, 64'h2,
		64'd0, 64'd0, 64'h43, 1'b1, 1'b0);
	addVec(execPkg::OpGrp1Iv, 1'b1, 3'd0, MaxPos, 64'd0, 2'b00, 64'd0, 64'd1, 64'h2,
		MinNeg, 64'd0, 64'h882, 1'b1, 1'b0);
	addVec(execPkg::OpAdcR, 1'b0, 3'd0, 64'd1, 64'd2, 2'b00, 64'd0, 64'd0, 64'h3,
		64'd4, 64'd0, 64'h2, 1'b1, 1'b0);
	addVec(execPkg::OpAdcAcc, 1'b0, 3'd0, AllOnes, 64'd0, 2'b00, 64'd0, 64'd0, 64'h3,
		64'd0, 64'd0, 64'h43, 1'b1, 1'b0);
	// Subtract family, borrow and overflow
	addVec(execPkg::OpSubR, 1'b0, 3'd0, 64'd3, 64'd5, 2'b00, 64'd0, 64'd0, 64'h2,
		AllOnes - 64'd1, 64'd0, 64'h83, 1'b1, 1'b0);
	addVec(execPkg::OpSubAcc, 1'b0, 3'd0, MinNeg, 64'd0, 2'b00, 64'd0, 64'd1, 64'h2,
		MaxPos, 64'd0, 64'h802, 1'b1, 1'b0);
	addVec(execPkg::OpSbbRm, 1'b0, 3'd0, 64'd10, 64'd3, 2'b00, 64'd0, 64'd0, 64'h3,
		64'd6, 64'd0, 64'h2, 1'b1, 1'b0);
	addVec(execPkg::OpGrp1Ib, 1'b1, 3'd3, 64'd0, 64'd0, 2'b00, 64'd0, 64'd0, 64'h3,
		AllOnes, 64'd0, 64'h83, 1'b1, 1'b0);
	addVec(execPkg::OpCmpRm, 1'b0, 3'd0, 64'd5, 64'd5, 2'b00, 64'd0, 64'd0, 64'h2,
		64'd0, 64'd0, 64'h42, 1'b1, 1'b0);
	addVec(execPkg::OpCmpAcc, 1'b0, 3'd0, 64'd1, 64'd0, 2'b00, 64'd0, 64'd2, 64'h2,
		AllOnes, 64'd0, 64'h83, 1'b1, 1'b0);
	// Logic ops clear CF and OF
	addVec(execPkg::OpAndRm, 1'b0, 3'd0, 64'hF0F0, 64'hFF00, 2'b00, 64'd0, 64'd0, 64'h803,
		64'hF000, 64'd0, 64'h2, 1'b1, 1'b0);
	addVec(execPkg::OpOrAcc, 1'b0, 3'd0, MinNeg, 64'd0, 2'b00, 64'd0, 64'd1, 64'h2,
		MinNeg + 64'd1, 64'd0, 64'h82, 1'b1, 1'b0);
	addVec(execPkg::OpXorR, 1'b0, 3'd0, 64'h1234, 64'h1234, 2'b00, 64'd0, 64'd0, 64'h803,
		64'd0, 64'd0, 64'h42, 1'b1, 1'b0);
	addVec(execPkg::OpGrp1Iv, 1'b1, 3'd6, AllOnes, 64'd0, 2'b00, 64'd0, 64'hF, 64'h2,
		AllOnes - 64'hF, 64'd0, 64'h82, 1'b1, 1'b0);
	addVec(execPkg::OpGrp3, 1'b1, 3'd2, 64'd0, 64'd0, 2'b00, 64'd0, 64'd0, 64'h3,
		AllOnes, 64'd0, 64'h3, 1'b1, 1'b0);
	// Moves and NOP keep the flags
	addVec(execPkg::OpMovImm, 1'b1, 3'd0, 64'd0, 64'd0, 2'b00, 64'd0, 64'hDEAD, 64'h843,
		64'hDEAD, 64'd0, 64'h843, 1'b1, 1'b0);
	addVec(execPkg::OpMovLoad, 1'b0, 3'd0, 64'd0, 64'h1111, 2'b10, 64'hABCD, 64'd0, 64'h2,
		64'hABCD, 64'd0, 64'h2, 1'b1, 1'b0);
	addVec(execPkg::OpMovRax, 1'b0, 3'd0, 64'd0, 64'd0, 2'b00, 64'd0, 64'h55, 64'h2,
		64'h55, 64'd0, 64'h2, 1'b1, 1'b0);
	addVec(execPkg::OpNop, 1'b0, 3'd0, 64'h99, 64'h77, 2'b00, 64'd0, 64'd0, 64'h883,
		64'd0, 64'd0, 64'h883, 1'b1, 1'b0);
	// NEG, INC, DEC, MUL
	addVec(execPkg::OpGrp3, 1'b1, 3'd3, 64'd5, 64'd0, 2'b00, 64'd0, 64'd0, 64'h2,
		AllOnes - 64'd4, 64'd0, 64'h83, 1'b1, 1'b0);
	addVec(execPkg::OpGrp3, 1'b1, 3'd3, 64'd5, 64'd0, 2'b01, MinNeg, 64'd0, 64'h2,
		MinNeg, 64'd0, 64'h883, 1'b1, 1'b0);
	addVec(execPkg::OpGrp5, 1'b1, 3'd0, MaxPos, 64'd0, 2'b00, 64'd0, 64'd0, 64'h3,
		MinNeg, 64'd0, 64'h883, 1'b1, 1'b0);
	addVec(execPkg::OpGrp5, 1'b1, 3'd1, MinNeg, 64'd0, 2'b00, 64'd0, 64'd0, 64'h3,
		MaxPos, 64'd0, 64'h803, 1'b1, 1'b0);
	addVec(execPkg::OpGrp5, 1'b1, 3'd1, 64'd1, 64'd0, 2'b00, 64'd0, 64'd0, 64'h2,
		64'd0, 64'd0, 64'h42, 1'b1, 1'b0);
	addVec(execPkg::OpGrp3, 1'b1, 3'd4, 64'd6, 64'd7, 2'b00, 64'd0, 64'd0, 64'h843,
		64'h2A, 64'd0, 64'h42, 1'b1, 1'b0);
	addVec(execPkg::OpGrp3, 1'b1, 3'd4, AllOnes, 64'd0, 2'b10, 64'd2, 64'd0, 64'h2,
		AllOnes - 64'd1, 64'd1, 64'h803, 1'b1, 1'b0);
	// Returns kill, bad encodings give ok low
	addVec(execPkg::OpRet, 1'b0, 3'd0, 64'd0, 64'd0, 2'b00, 64'd0, 64'd0, 64'h43,
		64'd0, 64'd0, 64'h43, 1'b1, 1'b1);
	addVec(execPkg::OpRetFar, 1'b0, 3'd0, 64'd0, 64'd0, 2'b00, 64'd0, 64'd0, 64'h2,
		64'd0, 64'd0, 64'h2, 1'b1, 1'b1);
	addVec(execPkg::opcodeE'(8'h0F), 1'b0, 3'd0, 64'd5, 64'd5, 2'b00, 64'd0, 64'd0, 64'h883,
		64'd0, 64'd0, 64'h883, 1'b0, 1'b0);
	addVec(execPkg::OpGrp3, 1'b1, 3'd0, 64'd5, 64'd5, 2'b00, 64'd0, 64'd0, 64'h2,
		64'd0, 64'd0, 64'h2, 1'b0, 1'b0);
	addVec(execPkg::OpGrp1Iv, 1'b0, 3'd0, 64'd5, 64'd0, 2'b00, 64'd0, 64'd1, 64'h2,
		64'd0, 64'd0, 64'h2, 1'b0, 1'b0);
endtask

// ==== dv/executeUnitTb.sv ====
// Testbench for the integer execute unit
// Table-driven stimulus, random stalls, in-order scoreboard with latency check
`default_nettype none

module executeUnitTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DataWidth = execPkg::DefaultDataWidth;
	localparam int ResetCycles = 4;
	localparam int IdleCycles = 4;
	// Upper bound on cycles to empty the pipeline under random stalls
	localparam int DrainLimit = 64;

	typedef logic [DataWidth-1:0] wordT;

	localparam wordT AllOnes = '1;
	localparam wordT MinNeg = {1'b1, {(DataWidth-1){1'b0}}};
	localparam wordT MaxPos = {1'b0, {(DataWidth-1){1'b1}}};

	typedef struct {
		execPkg::opcodeE op;
		logic hasExt;
		logic [2:0] ext;
		wordT a;
		wordT b;
		logic [1:0] memSel;
		wordT mem;
		wordT immVal;
		execPkg::flagsT fIn;
		wordT expRes;
		wordT expHigh;
		execPkg::flagsT expFlags;
		logic expOk;
		logic expKill;
	} vecT;

	// Accepted entry with the edge it was taken on
	typedef struct {
		int idx;
		int acceptEdge;
		int stallsBefore;
	} pendT;

	logic clk;
	logic rstN;
	logic opValid;
	logic canExecute;
	logic wbStall;
	execPkg::opcodeE opcode;
	logic hasExtOpcode;
	logic [2:0] extOpcode;
	wordT operand1;
	wordT operand2;
	logic memSrc1;
	logic memSrc2;
	wordT memData;
	wordT imm;
	execPkg::flagsT flagsIn;
	wordT result;
	wordT resultHigh;
	execPkg::flagsT flagsOut;
	logic done;
	logic executeOk;
	logic kill;

	vecT vecs[$];
	pendT expQ[$];
	integer seed = 32'h25f1ddde;
	int edgeCount;
	int stallCount;
	logic stalledLast;
	wordT heldResult;
	wordT heldHigh;
	execPkg::flagsT heldFlags;
	logic heldDone;
	logic heldOk;
	logic heldKill;

	executeUnit dut_i (
		.clk(clk),
		.rstN(rstN),
		.opValid(opValid),
		.canExecute(canExecute),
		.wbStall(wbStall),
		.opcode(opcode),
		.hasExtOpcode(hasExtOpcode),
		.extOpcode(extOpcode),
		.operand1(operand1),
		.operand2(operand2),
		.memSrc1(memSrc1),
		.memSrc2(memSrc2),
		.memData(memData),
		.imm(imm),
		.flagsIn(flagsIn),
		.result(result),
		.resultHigh(resultHigh),
		.flagsOut(flagsOut),
		.done(done),
		.executeOk(executeOk),
		.kill(kill)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abortRun(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1, "Run stopped");
	endtask

	task automatic reportError(input string msg);
		abortRun($sformatf("ERR @%0t: %s", $time, msg));
	endtask

	task automatic checkWord(input wordT got, input wordT exp, input string what);
		if (got !== exp) begin
			reportError($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	task automatic checkFlags(input execPkg::flagsT got, input execPkg::flagsT exp,
		input string what);
		if (got !== exp) begin
			reportError($sformatf("%s got %h expected %h", what, got, exp));
		end
	endtask

	task automatic checkStatus(input logic gotDone, input logic gotOk, input logic gotKill,
		input logic expDone, input logic expOk, input logic expKill, input string what);
		if ({gotDone, gotOk, gotKill} !== {expDone, expOk, expKill}) begin
			reportError($sformatf("%s done/ok/kill got %b%b%b expected %b%b%b", what,
				gotDone, gotOk, gotKill, expDone, expOk, expKill));
		end
	endtask

	task automatic addVec(input execPkg::opcodeE op, input logic hasExt, input logic [2:0] ext,
		input wordT a, input wordT b, input logic [1:0] memSel, input wordT mem,
		input wordT immVal, input execPkg::flagsT fIn, input wordT expRes,
		input wordT expHigh, input execPkg::flagsT expFlags, input logic expOk,
		input logic expKill);
		vecT v;
		v.op = op;
		v.hasExt = hasExt;
		v.ext = ext;
		v.a = a;
		v.b = b;
		v.memSel = memSel;
		v.mem = mem;
		v.immVal = immVal;
		v.fIn = fIn;
		v.expRes = expRes;
		v.expHigh = expHigh;
		v.expFlags = expFlags;
		v.expOk = expOk;
		v.expKill = expKill;
		vecs.push_back(v);
	endtask

	task automatic driveEntry(input int i);
		opValid = 1'b1;
		opcode = vecs[i].op;
		hasExtOpcode = vecs[i].hasExt;
		extOpcode = vecs[i].ext;
		operand1 = vecs[i].a;
		operand2 = vecs[i].b;
		memSrc1 = vecs[i].memSel[0];
		memSrc2 = vecs[i].memSel[1];
		memData = vecs[i].mem;
		imm = vecs[i].immVal;
		flagsIn = vecs[i].fIn;
	endtask

	task automatic randomizeControls();
		logic [31:0] rnd;
		rnd = $random(seed);
		canExecute = (rnd[1:0] != 2'b00);
		wbStall = (rnd[3:2] == 2'b00);
	endtask

	task automatic popAndCompare();
		pendT p;
		vecT v;
		string tag;
		if (expQ.size() == 0) begin
			abortRun("An output was delivered while no instruction was in flight");
		end else begin
			p = expQ.pop_front();
			v = vecs[p.idx];
			tag = $sformatf("entry %0d", p.idx);
			checkStatus(done, executeOk, kill, 1'b1, v.expOk, v.expKill, tag);
			checkWord(result, v.expRes, {tag, " result"});
			checkWord(resultHigh, v.expHigh, {tag, " resultHigh"});
			checkFlags(flagsOut, v.expFlags, {tag, " flags"});
			// Three edges plus one per stalled edge in between
			if (edgeCount - p.acceptEdge != 3 + stallCount - p.stallsBefore) begin
				reportError($sformatf("%s delivered %0d edges after accept with %0d stalls",
					tag, edgeCount - p.acceptEdge, stallCount - p.stallsBefore));
			end
		end
	endtask

	// Called at a falling edge once the inputs for the next rising edge are set
	task automatic stepCycle(input int idx);
		pendT p;
		if (stalledLast) begin
			checkStatus(done, executeOk, kill, heldDone, heldOk, heldKill, "status in stall");
			checkWord(result, heldResult, "result in stall");
			checkWord(resultHigh, heldHigh, "resultHigh in stall");
			checkFlags(flagsOut, heldFlags, "flags in stall");
		end
		if (done && !wbStall) begin
			popAndCompare();
		end
		if (opValid && canExecute && !wbStall) begin
			p.idx = idx;
			p.acceptEdge = edgeCount;
			p.stallsBefore = stallCount;
			expQ.push_back(p);
		end
		heldResult = result;
		heldHigh = resultHigh;
		heldFlags = flagsOut;
		heldDone = done;
		heldOk = executeOk;
		heldKill = kill;
		stalledLast = wbStall;
		if (wbStall) begin
			stallCount++;
		end
		edgeCount++;
		@(negedge clk);
	endtask

	initial begin
		logic accepted;
		int drainCycles;
		rstN = 1'b0;
		opValid = 1'b0;
		canExecute = 1'b0;
		wbStall = 1'b0;
		opcode = execPkg::OpNop;
		hasExtOpcode = 1'b0;
		extOpcode = 3'd0;
		operand1 = '0;
		operand2 = '0;
		memSrc1 = 1'b0;
		memSrc2 = 1'b0;
		memData = '0;
		imm = '0;
		flagsIn = '0;
		edgeCount = 0;
		stallCount = 0;
		stalledLast = 1'b0;
		loadVectors();
		repeat (ResetCycles) begin
			@(negedge clk);
			checkStatus(done, executeOk, kill, 1'b0, 1'b0, 1'b0, "status in reset");
		end
		rstN = 1'b1;
		// One idle edge out of reset with nothing offered
		@(negedge clk);
		checkStatus(done, executeOk, kill, 1'b0, 1'b0, 1'b0, "status after reset");

		// Back to back, one entry per cycle
		canExecute = 1'b1;
		for (int i = 0; i < vecs.size(); i++) begin
			driveEntry(i);
			stepCycle(i);
		end

		// Same table under random canExecute and wbStall
		for (int i = 0; i < vecs.size(); i++) begin
			accepted = 1'b0;
			while (!accepted) begin
				driveEntry(i);
				randomizeControls();
				accepted = canExecute && !wbStall;
				stepCycle(i);
			end
		end

		opValid = 1'b0;
		drainCycles = 0;
		while (expQ.size() != 0 && drainCycles < DrainLimit) begin
			randomizeControls();
			stepCycle(-1);
			drainCycles++;
		end
		wbStall = 1'b0;
		repeat (IdleCycles) begin
			stepCycle(-1);
		end

		if (expQ.size() != 0) begin
			abortRun("Instructions were still in flight at the end of the run");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

	// Two passes over the table fit well inside 20 cycles per entry
	initial begin
		@(posedge rstN);
		repeat (vecs.size() * 20 + ResetCycles + IdleCycles) @(posedge clk);
		abortRun("Timeout: the pipeline did not deliver all instructions in time");
	end

	`include "execVectors.svh"

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+dv
source/execPkg.sv
source/execStageIf.sv
source/decodeStage.sv
source/aluStage.sv
source/flagStage.sv
source/executeUnit.sv
dv/executeUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the execute unit testbench with Verilator, runs it and scans the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f build.f \
	--top-module executeUnitTb -o simExec \
	&& ./obj_dir/simExec > sim.log 2>&1 \
	|| echo "Finished with errors" >> sim.log
cat sim.log
if grep -q "Finished with errors" sim.log; then
	exit 1
fi
exit 0
